//--- compile.f
+incdir+include
hdl/exe_pkg.sv
hdl/alu.sv
hdl/exe_stage.sv
hdl/exe_top.sv
sim/exe_tb.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

BIN  := obj_dir/Vexe_tb
SRCS := $(filter-out +%,$(shell cat compile.f)) include/exe_vectors.svh

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module exe_tb -o Vexe_tb

# pass only if the testbench printed the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^SIMULATION PASSED$$'

clean:
	rm -rf obj_dir

//--- include/exe_vectors.svh
// directed execute vectors with expected results; included by the testbench module
`ifndef EXE_VECTORS_SVH
`define EXE_VECTORS_SVH

// one bundle, its expected result and idle cycles after it
typedef struct packed {
	exe_pkg::exe_req_t req;
	exe_pkg::xlen_t    alu_result;
	logic              redirect;
	exe_pkg::xlen_t    target;
	logic              wd;
	exe_pkg::reg_idx_t wreg;
	logic [1:0]        gap;
} exe_vec_t;

localparam int N_VEC = 27;

localparam exe_vec_t EXE_VECTORS [N_VEC] = '{
	// alu ops on reg1/reg2, target is just pc since imm is zero
	'{'{32'h0000_1000, 32'h0000_0005, 32'h0000_0003, 32'h0000_0000,
		exe_pkg::OP_ADD, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd1}, 32'h0000_0008, 1'b0, 32'h0000_1000, 1'b1, 5'd1, 2'd0},
	'{'{32'h0000_1004, 32'h0000_0003, 32'h0000_0005, 32'h0000_0000,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd2}, 32'hFFFF_FFFE, 1'b0, 32'h0000_1004, 1'b1, 5'd2, 2'd0},
	// shift by 0, then by 31 with junk in the upper shamt bits
	'{'{32'h0000_1008, 32'h8000_0001, 32'h0000_0000, 32'h0000_0000,
		exe_pkg::OP_SLL, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd3}, 32'h8000_0001, 1'b0, 32'h0000_1008, 1'b1, 5'd3, 2'd0},
	'{'{32'h0000_100C, 32'h0000_0001, 32'h0000_003F, 32'h0000_0000,
		exe_pkg::OP_SLL, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd4}, 32'h8000_0000, 1'b0, 32'h0000_100C, 1'b1, 5'd4, 2'd0},
	'{'{32'h0000_1010, 32'h8000_0000, 32'h0000_001F, 32'h0000_0000,
		exe_pkg::OP_SRL, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd5}, 32'h0000_0001, 1'b0, 32'h0000_1010, 1'b1, 5'd5, 2'd0},
	// negative value keeps its sign
	'{'{32'h0000_1014, 32'hF000_0000, 32'h0000_0004, 32'h0000_0000,
		exe_pkg::OP_SRA, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd6}, 32'hFF00_0000, 1'b0, 32'h0000_1014, 1'b1, 5'd6, 2'd2},
	// 0x8000_0000 vs 1, signed and unsigned disagree
	'{'{32'h0000_1018, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000,
		exe_pkg::OP_SLT, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd7}, 32'h0000_0001, 1'b0, 32'h0000_1018, 1'b1, 5'd7, 2'd0},
	'{'{32'h0000_101C, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000,
		exe_pkg::OP_SLTU, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd8}, 32'h0000_0000, 1'b0, 32'h0000_101C, 1'b1, 5'd8, 2'd0},
	'{'{32'h0000_1020, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0000_0000,
		exe_pkg::OP_XOR, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd9}, 32'h0FF0_0FF0, 1'b0, 32'h0000_1020, 1'b1, 5'd9, 2'd0},
	'{'{32'h0000_1024, 32'hF0F0_F0F0, 32'h0F00_000F, 32'h0000_0000,
		exe_pkg::OP_OR, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd10}, 32'hFFF0_F0FF, 1'b0, 32'h0000_1024, 1'b1, 5'd10, 2'd0},
	'{'{32'h0000_1028, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0000_0000,
		exe_pkg::OP_AND, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd11}, 32'hF000_F000, 1'b0, 32'h0000_1028, 1'b1, 5'd11, 2'd1},
	// lui through pass2, auipc as pc plus imm
	'{'{32'h0000_102C, 32'h0000_0000, 32'h0000_0000, 32'hDEAD_B000,
		exe_pkg::OP_PASS2, exe_pkg::SRC1_ZERO, exe_pkg::SRC2_IMM, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd12}, 32'hDEAD_B000, 1'b0, 32'hDEAD_C02C, 1'b1, 5'd12, 2'd0},
	'{'{32'h0000_1030, 32'h0000_0000, 32'h0000_0000, 32'h0000_2000,
		exe_pkg::OP_ADD, exe_pkg::SRC1_PC, exe_pkg::SRC2_IMM, exe_pkg::BR_NONE,
		exe_pkg::TGT_PC, 1'b1, 5'd13}, 32'h0000_3030, 1'b0, 32'h0000_3030, 1'b1, 5'd13, 2'd0},
	// compare branches, taken then not taken for each type
	'{'{32'h0000_1034, 32'h0000_0007, 32'h0000_0007, 32'h0000_0010,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_EQ,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h0000_0000, 1'b1, 32'h0000_1044, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_1038, 32'h0000_0007, 32'h0000_0008, 32'h0000_0010,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_EQ,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'hFFFF_FFFF, 1'b0, 32'h0000_1048, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_103C, 32'h0000_0007, 32'h0000_0008, 32'hFFFF_FFF8,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NE,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'hFFFF_FFFF, 1'b1, 32'h0000_1034, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_1040, 32'h0000_0007, 32'h0000_0007, 32'h0000_0020,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_NE,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h0000_0000, 1'b0, 32'h0000_1060, 1'b0, 5'd0, 2'd0},
	// signed overflow case, min int below 1
	'{'{32'h0000_1044, 32'h8000_0000, 32'h0000_0001, 32'h0000_0040,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_LT,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h7FFF_FFFF, 1'b1, 32'h0000_1084, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_1048, 32'h0000_0005, 32'h0000_0005, 32'h0000_0040,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_LT,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h0000_0000, 1'b0, 32'h0000_1088, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_104C, 32'h0000_0005, 32'h0000_0005, 32'h0000_0010,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_GE,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h0000_0000, 1'b1, 32'h0000_105C, 1'b0, 5'd0, 2'd3},
	'{'{32'h0000_1050, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0010,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_GE,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'hFFFF_FFFE, 1'b0, 32'h0000_1060, 1'b0, 5'd0, 2'd0},
	// unsigned view of the same values
	'{'{32'h0000_1054, 32'h0000_0001, 32'h8000_0000, 32'h0000_0100,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_LTU,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h8000_0001, 1'b1, 32'h0000_1154, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_1058, 32'h8000_0000, 32'h0000_0001, 32'h0000_0100,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_LTU,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h7FFF_FFFF, 1'b0, 32'h0000_1158, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_105C, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFF0,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_GEU,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'hFFFF_FFFE, 1'b1, 32'h0000_104C, 1'b0, 5'd0, 2'd0},
	'{'{32'h0000_1060, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0008,
		exe_pkg::OP_SUB, exe_pkg::SRC1_REG1, exe_pkg::SRC2_REG2, exe_pkg::BR_GEU,
		exe_pkg::TGT_PC, 1'b0, 5'd0}, 32'h0000_0002, 1'b0, 32'h0000_1068, 1'b0, 5'd0, 2'd0},
	// jal, link is pc plus four
	'{'{32'h0000_1064, 32'h0000_0000, 32'h0000_0000, 32'h0000_0200,
		exe_pkg::OP_ADD, exe_pkg::SRC1_PC, exe_pkg::SRC2_FOUR, exe_pkg::BR_JUMP,
		exe_pkg::TGT_PC, 1'b1, 5'd1}, 32'h0000_1068, 1'b1, 32'h0000_1264, 1'b1, 5'd1, 2'd0},
	// jalr x0 with odd sum, bit 0 cleared
	'{'{32'h0000_1068, 32'h0000_2001, 32'h0000_0000, 32'h0000_0004,
		exe_pkg::OP_ADD, exe_pkg::SRC1_PC, exe_pkg::SRC2_FOUR, exe_pkg::BR_JUMP,
		exe_pkg::TGT_REG1, 1'b1, 5'd0}, 32'h0000_106C, 1'b1, 32'h0000_2004, 1'b1, 5'd0, 2'd0}
};

`endif

//--- sim/exe_tb.sv
// self-checking testbench for exe_top: directed table, random alu bundles, reset and latency checks
module exe_tb;

	timeunit 1ns;
	timeprecision 1ps;

	`include "exe_vectors.svh"

	localparam int          N_RAND     = 64;
	localparam int          MAX_CYCLES = N_VEC + N_RAND + 40;
	localparam logic [31:0] SEED       = 32'hb8012e3f;

	// what the monitor expects for one issued bundle
	typedef struct {
		exe_pkg::xlen_t    alu_result;
		logic              redirect;
		exe_pkg::xlen_t    target;
		logic              wd;
		exe_pkg::reg_idx_t wreg;
		int                cycle;
	} exp_t;

	logic              clk_i;
	logic              rst_i;
	logic              valid_i;
	exe_pkg::exe_req_t req_i;
	logic              valid_o;
	exe_pkg::exe_rsp_t rsp_o;

	exp_t exp_q[$];
	int   errors = 0;
	int   checks = 0;
	// posedges seen so far
	int   cycles = 0;

	exe_top #(
		.DATA_W (exe_pkg::DATA_W)
	) exe_top_i (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.req_i   (req_i),
		.valid_o (valid_o),
		.rsp_o   (rsp_o)
	);

	// 10 ns clock
	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// run limit
	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	// reference for the random ops
	function automatic exe_pkg::xlen_t expected_alu(input exe_pkg::alu_op_t op,
		input exe_pkg::xlen_t a, input exe_pkg::xlen_t b);
		case (op)
			exe_pkg::OP_SUB: return a - b;
			exe_pkg::OP_XOR: return a ^ b;
			default:         return a + b;
		endcase
	endfunction

	// strobe one bundle on the falling edge, remember its cycle
	task automatic drive_bundle(input exe_pkg::exe_req_t req, input exp_t exp);
		@(negedge clk_i);
		req_i   = req;
		valid_i = 1'b1;
		exp.cycle = cycles;
		exp_q.push_back(exp);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk_i);
			valid_i = 1'b0;
		end
	endtask

	// outputs that must stay low around reset
	task automatic check_quiet();
		check("valid_o", 32'(1'b0), 32'(valid_o));
		check("rsp_o.redirect", 32'(1'b0), 32'(rsp_o.redirect));
		check("rsp_o.wd", 32'(1'b0), 32'(rsp_o.wd));
	endtask

	// result monitor, a step after the falling edge so pushes of the same edge are done
	always @(negedge clk_i) begin
		exp_t head;
		#1;
		if (!rst_i && valid_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("unexpected result on valid_o at %0t with nothing outstanding", $time);
			end else begin
				head = exp_q.pop_front();
				// two edges from strobe to valid_o
				check("latency", 32'(head.cycle + 2), 32'(cycles));
				check("rsp_o.alu_result", head.alu_result, rsp_o.alu_result);
				check("rsp_o.redirect", 32'(head.redirect), 32'(rsp_o.redirect));
				check("rsp_o.target", head.target, rsp_o.target);
				check("rsp_o.wd", 32'(head.wd), 32'(rsp_o.wd));
				check("rsp_o.wreg", 32'(head.wreg), 32'(rsp_o.wreg));
			end
		end
	end

	initial begin
		exe_pkg::exe_req_t stray;
		exe_pkg::exe_req_t r;
		exp_t              e;
		exe_vec_t          v;
		int                drain;

		void'($urandom(SEED));
		rst_i   = 1'b1;
		valid_i = 1'b0;
		req_i   = '0;

		// jump with write enable, strobed on the last edge that still sees reset
		stray         = '0;
		stray.pc      = 32'h0000_0400;
		stray.imm     = 32'h0000_0010;
		stray.br_type = exe_pkg::BR_JUMP;
		stray.wd      = 1'b1;
		stray.wreg    = 5'd9;

		// four reset cycles
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_i);
			if (i > 0) begin
				check_quiet();
			end
			req_i   = (i == 2) ? stray : '0;
			valid_i = (i == 2);
			if (i == 3) begin
				rst_i = 1'b0;
			end
		end

		// stray strobe must not leak out after release
		repeat (2) begin
			@(negedge clk_i);
			check_quiet();
		end

		// directed table, back to back with some gaps
		for (int i = 0; i < N_VEC; i++) begin
			v            = EXE_VECTORS[i];
			e.alu_result = v.alu_result;
			e.redirect   = v.redirect;
			e.target     = v.target;
			e.wd         = v.wd;
			e.wreg       = v.wreg;
			drive_bundle(v.req, e);
			if (v.gap != 2'd0) begin
				idle_cycles(int'(v.gap));
			end
		end

		// random add/xor/sub on registers
		for (int i = 0; i < N_RAND; i++) begin
			r          = '0;
			r.pc       = $urandom & 32'hFFFF_FFFC;
			r.reg1     = $urandom;
			r.reg2     = $urandom;
			r.imm      = $urandom;
			r.src1_sel = exe_pkg::SRC1_REG1;
			r.src2_sel = exe_pkg::SRC2_REG2;
			r.br_type  = exe_pkg::BR_NONE;
			r.tgt_sel  = exe_pkg::TGT_PC;
			r.wd       = 1'($urandom);
			r.wreg     = 5'($urandom);
			case ($urandom_range(2, 0))
				0:       r.alu_op = exe_pkg::OP_ADD;
				1:       r.alu_op = exe_pkg::OP_XOR;
				default: r.alu_op = exe_pkg::OP_SUB;
			endcase
			e.alu_result = expected_alu(r.alu_op, r.reg1, r.reg2);
			e.redirect   = 1'b0;
			e.target     = r.pc + r.imm;
			e.wd         = r.wd;
			e.wreg       = r.wreg;
			drive_bundle(r, e);
		end
		idle_cycles(1);

		// wait for the pipe to drain
		drain = 0;
		while (exp_q.size() != 0 && drain < 8) begin
			@(negedge clk_i);
			drain++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d results were missing at the end of the run", exp_q.size());
		end
		// idle tail, nothing may come out
		idle_cycles(3);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- hdl/exe_top.sv
// execute stage top with issue and result registers; the unit the core pipeline instantiates
module exe_top #(
	parameter int DATA_W = exe_pkg::DATA_W
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              valid_i,
	input  exe_pkg::exe_req_t req_i,
	output logic              valid_o,
	output exe_pkg::exe_rsp_t rsp_o
);

	// issue slot
	logic              issue_valid;
	exe_pkg::exe_req_t issue_req;
	// combinational result of the stage
	exe_pkg::exe_rsp_t stage_rsp;

	// issue register
	// bundle only loads on a strobe, valid bit every edge
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			issue_req <= req_i;
		end
		if (rst_i) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= valid_i;
		end
	end

	exe_stage #(
		.DATA_W (DATA_W)
	) exe_stage_i (
		.req_i (issue_req),
		.rsp_o (stage_rsp)
	);

	// result register
	always_ff @(posedge clk_i) begin
		// data fields, meaningless while valid_o is low
		rsp_o.alu_result <= stage_rsp.alu_result;
		rsp_o.target     <= stage_rsp.target;
		rsp_o.wreg       <= stage_rsp.wreg;
		if (rst_i) begin
			valid_o        <= 1'b0;
			rsp_o.redirect <= 1'b0;
			rsp_o.wd       <= 1'b0;
		end else begin
			valid_o <= issue_valid;
			// stale bundle in the issue slot must not redirect or write
			rsp_o.redirect <= issue_valid & stage_rsp.redirect;
			rsp_o.wd       <= issue_valid & stage_rsp.wd;
		end
	end

	// every issued bundle reaches the output on the next edge
	// with its own write-back fields carried through the stage
	a_valid_follows: assert property (@(posedge clk_i) disable iff (rst_i)
		issue_valid |=> valid_o && rsp_o.wd == $past(issue_req.wd) &&
			rsp_o.wreg == $past(issue_req.wreg))
		else $error("issued bundle did not reach the output with its write-back fields");

	// no fetch redirect without a result behind it
	// and only a branch or jump may redirect
	a_no_idle_redirect: assert property (@(posedge clk_i) disable iff (rst_i)
		rsp_o.redirect |-> valid_o && $past(issue_req.br_type) != exe_pkg::BR_NONE)
		else $error("redirect high without a valid branch or jump behind it");

	// write to x0 is legal, e.g. jalr x0 for a return
	// flagged so the write-back side can be checked for ignoring it
	c_wd_x0: cover property (@(posedge clk_i) disable iff (rst_i)
		valid_o && rsp_o.wd && (rsp_o.wreg == '0))
		$warning("result writes register x0");

endmodule

//--- hdl/exe_stage.sv
// combinational execute: operand muxes, alu, branch decision and target; used in exe_top
module exe_stage #(
	parameter int DATA_W = exe_pkg::DATA_W
) (
	input  exe_pkg::exe_req_t req_i,
	output exe_pkg::exe_rsp_t rsp_o
);

	exe_pkg::xlen_t src1;
	exe_pkg::xlen_t src2;
	exe_pkg::xlen_t alu_result;
	// base and sum of the branch/jump target adder
	exe_pkg::xlen_t tgt_base;
	exe_pkg::xlen_t tgt_sum;
	logic           eq;
	logic           lt;
	logic           ltu;
	logic           taken;
	// one of the six compare branches
	logic           is_cond_br;

	// first operand
	always_comb begin
		case (req_i.src1_sel)
			exe_pkg::SRC1_REG1: src1 = req_i.reg1;
			exe_pkg::SRC1_PC:   src1 = req_i.pc;
			default:            src1 = '0;
		endcase
	end

	// second operand, four gives the link address
	always_comb begin
		case (req_i.src2_sel)
			exe_pkg::SRC2_REG2: src2 = req_i.reg2;
			exe_pkg::SRC2_IMM:  src2 = req_i.imm;
			exe_pkg::SRC2_FOUR: src2 = exe_pkg::xlen_t'(4);
			default:            src2 = '0;
		endcase
	end

	alu #(
		.DATA_W (DATA_W)
	) alu_i (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (req_i.alu_op),
		.result_o (alu_result),
		.eq_o     (eq),
		.lt_o     (lt),
		.ltu_o    (ltu)
	);

	// branch decision from the alu flags
	// flags compare reg1 against reg2 for branches
	always_comb begin
		case (req_i.br_type)
			exe_pkg::BR_EQ:   taken = eq;
			exe_pkg::BR_NE:   taken = ~eq;
			exe_pkg::BR_LT:   taken = lt;
			exe_pkg::BR_GE:   taken = ~lt;
			exe_pkg::BR_LTU:  taken = ltu;
			exe_pkg::BR_GEU:  taken = ~ltu;
			exe_pkg::BR_JUMP: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	assign is_cond_br = (req_i.br_type != exe_pkg::BR_NONE) &&
		(req_i.br_type != exe_pkg::BR_JUMP);

	// separate adder, the alu is busy with the link value on jumps
	assign tgt_base = (req_i.tgt_sel == exe_pkg::TGT_REG1) ? req_i.reg1 : req_i.pc;
	assign tgt_sum  = tgt_base + req_i.imm;

	always_comb begin
		rsp_o.alu_result = alu_result;
		rsp_o.redirect   = taken;
		rsp_o.target     = tgt_sum;
		// jalr drops bit 0 of the sum
		if (req_i.tgt_sel == exe_pkg::TGT_REG1) begin
			rsp_o.target[0] = 1'b0;
		end
		// write-back fields ride along untouched
		rsp_o.wd   = req_i.wd;
		rsp_o.wreg = req_i.wreg;
	end

	// decoder must route both registers into the alu for a compare branch,
	// otherwise the flags compare the wrong values
	always_comb begin
		if (is_cond_br) begin
			a_cond_br_regs: assert (req_i.src1_sel == exe_pkg::SRC1_REG1 &&
				req_i.src2_sel == exe_pkg::SRC2_REG2)
				else $error("conditional branch decoded without reg1/reg2 operands");
		end
	end

endmodule

//--- hdl/alu.sv
// rv32i integer alu with compare flags from one subtractor; instantiated by exe_stage
module alu #(
	parameter int DATA_W = exe_pkg::DATA_W
) (
	input  exe_pkg::xlen_t   src1_i,
	input  exe_pkg::xlen_t   src2_i,
	input  exe_pkg::alu_op_t op_i,
	output exe_pkg::xlen_t   result_o,
	output logic             eq_o,
	output logic             lt_o,
	output logic             ltu_o
);

	// shift amount width follows the package type
	localparam int SH_W = $bits(exe_pkg::shamt_t);

	// extra top bit holds the borrow
	logic [DATA_W:0]   diff;
	logic [DATA_W-1:0] sum;
	// signed overflow of src1 - src2
	logic              ovf;
	exe_pkg::shamt_t   shamt;

	assign sum  = src1_i + src2_i;
	assign diff = {1'b0, src1_i} - {1'b0, src2_i};

	// only the low bits shift, as rv32i wants
	assign shamt = src2_i[SH_W-1:0];

	// zero difference means equal
	assign eq_o  = (diff[DATA_W-1:0] == '0);
	// borrow out means unsigned less
	assign ltu_o = diff[DATA_W];

	// overflow when the signs differ
	// and the difference lands on the sign of src2
	assign ovf = (src1_i[DATA_W-1] ^ src2_i[DATA_W-1]) &
		(diff[DATA_W-1] ^ src1_i[DATA_W-1]);

	// sign of the true difference
	assign lt_o = diff[DATA_W-1] ^ ovf;

	always_comb begin
		case (op_i)
			exe_pkg::OP_ADD: begin
				result_o = sum;
			end
			exe_pkg::OP_SUB: begin
				// same subtractor as the flags
				result_o = diff[DATA_W-1:0];
			end
			exe_pkg::OP_SLL: begin
				result_o = src1_i << shamt;
			end
			exe_pkg::OP_SRL: begin
				result_o = src1_i >> shamt;
			end
			exe_pkg::OP_SRA: begin
				// sign fill from bit 31
				result_o = $signed(src1_i) >>> shamt;
			end
			exe_pkg::OP_SLT: begin
				result_o = exe_pkg::xlen_t'(lt_o);
			end
			exe_pkg::OP_SLTU: begin
				result_o = exe_pkg::xlen_t'(ltu_o);
			end
			exe_pkg::OP_XOR: begin
				result_o = src1_i ^ src2_i;
			end
			exe_pkg::OP_OR: begin
				result_o = src1_i | src2_i;
			end
			exe_pkg::OP_AND: begin
				result_o = src1_i & src2_i;
			end
			exe_pkg::OP_PASS2: begin
				// lui path, src1 is ignored
				result_o = src2_i;
			end
			default: begin
				// unused op codes give zero
				result_o = '0;
			end
		endcase
	end

endmodule

//--- hdl/exe_pkg.sv
// widths, operation and selector codes and bundle structs shared by the execute stage rtl
package exe_pkg;

	// default datapath width, modules take it as their DATA_W default
	localparam int DATA_W = 32;

	// one data word
	typedef logic [DATA_W-1:0] xlen_t;
	// architectural register index
	typedef logic [4:0] reg_idx_t;
	// shift amount, low bits of the second operand
	typedef logic [4:0] shamt_t;

	// alu operation codes
	typedef logic [3:0] alu_op_t;
	localparam alu_op_t OP_ADD   = 4'b0000;
	localparam alu_op_t OP_SUB   = 4'b0001;
	localparam alu_op_t OP_SLL   = 4'b0010;
	localparam alu_op_t OP_SLT   = 4'b0011;
	localparam alu_op_t OP_SLTU  = 4'b0100;
	localparam alu_op_t OP_XOR   = 4'b0101;
	localparam alu_op_t OP_SRL   = 4'b0110;
	localparam alu_op_t OP_SRA   = 4'b0111;
	localparam alu_op_t OP_OR    = 4'b1000;
	localparam alu_op_t OP_AND   = 4'b1001;
	// second operand straight through, used for lui
	localparam alu_op_t OP_PASS2 = 4'b1010;

	// first operand source
	typedef logic [1:0] src1_sel_t;
	localparam src1_sel_t SRC1_ZERO = 2'b00;
	localparam src1_sel_t SRC1_REG1 = 2'b01;
	localparam src1_sel_t SRC1_PC   = 2'b10;

	// second operand source
	typedef logic [1:0] src2_sel_t;
	localparam src2_sel_t SRC2_ZERO = 2'b00;
	localparam src2_sel_t SRC2_REG2 = 2'b01;
	localparam src2_sel_t SRC2_IMM  = 2'b10;
	// link value offset for jal/jalr
	localparam src2_sel_t SRC2_FOUR = 2'b11;

	// branch condition
	typedef logic [2:0] br_type_t;
	localparam br_type_t BR_NONE = 3'd0;
	localparam br_type_t BR_EQ   = 3'd1;
	localparam br_type_t BR_NE   = 3'd2;
	localparam br_type_t BR_LT   = 3'd3;
	localparam br_type_t BR_GE   = 3'd4;
	localparam br_type_t BR_LTU  = 3'd5;
	localparam br_type_t BR_GEU  = 3'd6;
	// unconditional, jal and jalr
	localparam br_type_t BR_JUMP = 3'd7;

	// target base, pc for jal/branches, reg1 for jalr
	typedef logic tgt_sel_t;
	localparam tgt_sel_t TGT_PC   = 1'b0;
	localparam tgt_sel_t TGT_REG1 = 1'b1;

	// decoded bundle handed to execute
	typedef struct packed {
		xlen_t     pc;
		xlen_t     reg1;
		xlen_t     reg2;
		xlen_t     imm;
		alu_op_t   alu_op;
		src1_sel_t src1_sel;
		src2_sel_t src2_sel;
		br_type_t  br_type;
		tgt_sel_t  tgt_sel;
		logic      wd;
		reg_idx_t  wreg;
	} exe_req_t;

	// execute result toward memory/write-back
	typedef struct packed {
		xlen_t    alu_result;
		logic     redirect;
		xlen_t    target;
		logic     wd;
		reg_idx_t wreg;
	} exe_rsp_t;

endpackage
